// ==== design/game_audio.sv ====
`timescale 1ns/1ns

module game_audio (
	input  logic                          clk,
	input  logic                          resetN,
	input  game_audio_pkg::game_events_t  events,
	output game_audio_pkg::audio_status_t status,
	output logic                          tone
);

	import game_audio_pkg::*;

	logic       start;
	logic       stop;
	logic       done;
	logic       load;
	logic       expired;
	logic [2:0] units;
	melody_t    melody;
	pitch_t     pitch;

	sfx_arbiter u_arbiter (
		.clk    (clk),
		.resetN (resetN),
		.events (events),
		.done   (done),
		.start  (start),
		.stop   (stop),
		.melody (melody)
	);

	melody_sequencer u_sequencer (
		.clk     (clk),
		.resetN  (resetN),
		.start   (start),
		.stop    (stop),
		.melody  (melody),
		.expired (expired),
		.load    (load),
		.units   (units),
		.pitch   (pitch),
		.done    (done),
		.status  (status)
	);

	note_timer u_timer (
		.clk     (clk),
		.resetN  (resetN),
		.load    (load),
		.units   (units),
		.expired (expired)
	);

	tone_generator u_tone (
		.clk    (clk),
		.resetN (resetN),
		.pitch  (pitch),
		.tone   (tone)
	);

endmodule

// ==== design/game_audio_macros.svh ====
`ifndef GAME_AUDIO_MACROS_SVH
`define GAME_AUDIO_MACROS_SVH

// ******************************
// Note timing
// ******************************

// Clock cycles in one note unit.
`define NOTE_UNIT_CYCLES 8

// Longest melody in the table.
`define MELODY_MAX_NOTES 4

// ******************************
// Tone half-periods in cycles
// ******************************

`define HALF_PERIOD_C 3'd7
`define HALF_PERIOD_D 3'd6
`define HALF_PERIOD_E 3'd5
`define HALF_PERIOD_F 3'd4
`define HALF_PERIOD_G 3'd3
`define HALF_PERIOD_A 3'd2

`endif

// ==== design/game_audio_pkg.sv ====
package game_audio_pkg;

	// ******************************
	// Game event inputs
	// ******************************

	// Pulses unless noted otherwise.
	typedef struct packed {
		logic jewel;
		logic speed_up;
		logic extra_life;
		logic bomb;
		logic time_bonus;
		logic objective;
		logic player_hit;
		logic game_lost;
		logic score_reset;
		logic main_menu;   // Level, high while the menu is shown.
		logic game_on;     // Level, high during a running game.
	} game_events_t;

	// ******************************
	// Tunes and arbiter states
	// ******************************

	typedef enum logic [2:0] {
		mel_none,
		mel_menu,
		mel_menu_exit,
		mel_hit,
		mel_lost,
		mel_power,
		mel_jewel,
		mel_objective
	} melody_t;

	typedef enum logic [1:0] {
		st_idle,
		st_play,
		st_wait_reset,
		st_menu
	} arb_state_t;

	// ******************************
	// Notes and status
	// ******************************

	typedef enum logic [2:0] {
		p_rest,
		p_c,
		p_d,
		p_e,
		p_f,
		p_g,
		p_a
	} pitch_t;

	// Length is in note units, 1 to 7.
	typedef struct packed {
		pitch_t     pitch;
		logic [2:0] units;
	} note_t;

	typedef struct packed {
		logic       playing;
		melody_t    melody;
		logic [2:0] note_index;
	} audio_status_t;

endpackage

// ==== design/melody_sequencer.sv ====
`timescale 1ns/1ns

`include "game_audio_macros.svh"

module melody_sequencer (
	input  logic                          clk,
	input  logic                          resetN,
	input  logic                          start,
	input  logic                          stop,
	input  game_audio_pkg::melody_t       melody,
	input  logic                          expired,
	output logic                          load,
	output logic [2:0]                    units,
	output game_audio_pkg::pitch_t        pitch,
	output logic                          done,
	output game_audio_pkg::audio_status_t status
);

	import game_audio_pkg::*;

	localparam int IDX_W = $clog2(`MELODY_MAX_NOTES);

	typedef note_t [`MELODY_MAX_NOTES-1:0] note_row_t;

	// ******************************
	// Melody table
	// ******************************

	function automatic note_row_t melody_row(melody_t m);
		note_row_t row;
		row = '0;
		case (m)
			mel_jewel: begin
				row[0] = '{p_c, 3'd1};
				row[1] = '{p_e, 3'd1};
				row[2] = '{p_g, 3'd1};
				row[3] = '{p_a, 3'd2};
			end
			mel_power: begin
				row[0] = '{p_e, 3'd2};
				row[1] = '{p_g, 3'd2};
			end
			mel_objective: begin
				row[0] = '{p_c, 3'd1};
				row[1] = '{p_d, 3'd1};
				row[2] = '{p_e, 3'd1};
				row[3] = '{p_f, 3'd3};
			end
			mel_hit: begin
				row[0] = '{p_a, 3'd1};
				row[1] = '{p_rest, 3'd1};
				row[2] = '{p_a, 3'd1};
			end
			mel_lost: begin
				row[0] = '{p_g, 3'd2};
				row[1] = '{p_f, 3'd2};
				row[2] = '{p_e, 3'd2};
				row[3] = '{p_c, 3'd4};
			end
			mel_menu: begin
				row[0] = '{p_c, 3'd3};
				row[1] = '{p_e, 3'd3};
				row[2] = '{p_g, 3'd3};
				row[3] = '{p_e, 3'd3};
			end
			mel_menu_exit: row[0] = '{p_g, 3'd1};
			default: row[0] = '{p_rest, 3'd1};
		endcase
		return row;
	endfunction

	function automatic logic [2:0] note_count(melody_t m);
		case (m)
			mel_jewel, mel_objective, mel_lost, mel_menu: return 3'd4;
			mel_hit: return 3'd3;
			mel_power: return 3'd2;
			default: return 3'd1;
		endcase
	endfunction

	// ******************************
	// Note stepping
	// ******************************

	melody_t          mel_q;
	logic             playing;
	logic [2:0]       note_index;
	logic             last_note;
	logic [IDX_W-1:0] cur_slot;
	logic [IDX_W-1:0] next_slot;
	note_row_t        cur_row;
	note_row_t        new_row;

	assign cur_row   = melody_row(mel_q);
	assign new_row   = melody_row(melody);
	assign cur_slot  = note_index[IDX_W-1:0];
	assign next_slot = cur_slot + IDX_W'(1);
	assign last_note = (note_index == note_count(mel_q) - 3'd1);

	// The timer reloads in the same cycle that the old note expires.
	assign load   = start || (playing && expired && !last_note);
	assign units  = start ? new_row[0].units : cur_row[next_slot].units;
	assign done   = playing && expired && last_note;
	assign pitch  = playing ? cur_row[cur_slot].pitch : p_rest;
	assign status = '{playing: playing, melody: mel_q, note_index: note_index};

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			playing    <= 1'b0;
			mel_q      <= mel_none;
			note_index <= 3'd0;
		end else if (start) begin
			playing    <= 1'b1;
			mel_q      <= melody;
			note_index <= 3'd0;
		end else if (stop) begin
			playing    <= 1'b0;
			note_index <= 3'd0;
		end else if (playing && expired) begin
			if (last_note)
				playing <= 1'b0;
			else
				note_index <= note_index + 3'd1;
		end
	end

endmodule

// ==== design/note_timer.sv ====
`timescale 1ns/1ns

`include "game_audio_macros.svh"

module note_timer (
	input  logic       clk,
	input  logic       resetN,
	input  logic       load,
	input  logic [2:0] units,
	output logic       expired
);

	// Wide enough for the longest note of 7 units.
	localparam int CNT_W = $clog2(7 * `NOTE_UNIT_CYCLES);

	logic [CNT_W-1:0] count;
	logic             active;

	// Last cycle of the note.
	assign expired = active && (count == '0);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			count  <= '0;
			active <= 1'b0;
		end else if (load) begin
			count  <= CNT_W'(units) * CNT_W'(`NOTE_UNIT_CYCLES) - CNT_W'(1);
			active <= 1'b1;
		end else if (active) begin
			if (count == '0)
				active <= 1'b0;
			else
				count <= count - CNT_W'(1);
		end
	end

endmodule

// ==== design/sfx_arbiter.sv ====
`timescale 1ns/1ns

module sfx_arbiter (
	input  logic                         clk,
	input  logic                         resetN,
	input  game_audio_pkg::game_events_t events,
	input  logic                         done,
	output logic                         start,
	output logic                         stop,
	output game_audio_pkg::melody_t      melody
);

	import game_audio_pkg::*;

	arb_state_t state;
	melody_t    pick;
	melody_t    pending;
	logic       launch;
	logic       lost_armed;
	logic       menu_played;

	// ******************************
	// Idle priority
	// ******************************

	always_comb begin
		pick = mel_none;
		if (events.jewel)
			pick = mel_jewel;
		else if (events.speed_up || events.extra_life || events.bomb || events.time_bonus)
			pick = mel_power;
		else if (events.objective && events.game_on)
			pick = mel_objective;
		else if (events.player_hit)
			pick = mel_hit;
		else if (events.game_lost && lost_armed)
			pick = mel_lost;
		else if (events.main_menu && !menu_played)
			pick = mel_menu;
	end

	// ******************************
	// State machine
	// ******************************

	// A decision is held in pending for one cycle; start follows it.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state       <= st_idle;
			pending     <= mel_none;
			melody      <= mel_none;
			launch      <= 1'b0;
			start       <= 1'b0;
			stop        <= 1'b0;
			lost_armed  <= 1'b1;
			menu_played <= 1'b0;
		end else begin
			start  <= launch;
			stop   <= 1'b0;
			launch <= 1'b0;
			if (launch)
				melody <= pending;
			// The menu tune plays once per menu visit.
			if (!events.main_menu)
				menu_played <= 1'b0;

			case (state)
				st_idle: begin
					if (pick != mel_none) begin
						launch  <= 1'b1;
						pending <= pick;
						if (pick == mel_menu) begin
							state       <= st_menu;
							menu_played <= 1'b1;
						end else begin
							state <= st_play;
						end
						if (pick == mel_lost)
							lost_armed <= 1'b0;
					end
				end

				// A done from a cut-short tune may still show while launching.
				st_play: begin
					if (done && !launch)
						state <= lost_armed ? st_idle : st_wait_reset;
				end

				st_wait_reset: begin
					if (events.score_reset) begin
						lost_armed <= 1'b1;
						state      <= st_idle;
					end
				end

				st_menu: begin
					if (!launch && (done || !events.main_menu)) begin
						stop    <= !done;
						launch  <= 1'b1;
						pending <= mel_menu_exit;
						state   <= st_play;
					end
				end

				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== design/tone_generator.sv ====
`timescale 1ns/1ns

`include "game_audio_macros.svh"

module tone_generator (
	input  logic                   clk,
	input  logic                   resetN,
	input  game_audio_pkg::pitch_t pitch,
	output logic                   tone
);

	import game_audio_pkg::*;

	function automatic logic [2:0] half_period(pitch_t p);
		case (p)
			p_c: return `HALF_PERIOD_C;
			p_d: return `HALF_PERIOD_D;
			p_e: return `HALF_PERIOD_E;
			p_f: return `HALF_PERIOD_F;
			p_g: return `HALF_PERIOD_G;
			p_a: return `HALF_PERIOD_A;
			default: return 3'd7;
		endcase
	endfunction

	pitch_t     last_pitch;
	logic [2:0] half_cnt;
	logic [2:0] half_len;

	assign half_len = half_period(pitch);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tone       <= 1'b0;
			half_cnt   <= 3'd0;
			last_pitch <= p_rest;
		end else begin
			last_pitch <= pitch;
			if (pitch == p_rest) begin
				tone     <= 1'b0;
				half_cnt <= 3'd0;
			end else if (pitch != last_pitch) begin
				// The edge that sees the change already counts.
				tone     <= 1'b0;
				half_cnt <= 3'd1;
			end else if (half_cnt == half_len - 3'd1) begin
				tone     <= ~tone;
				half_cnt <= 3'd0;
			end else begin
				half_cnt <= half_cnt + 3'd1;
			end
		end
	end

endmodule

// ==== game_audio.f ====
+incdir+design
design/game_audio_pkg.sv
design/note_timer.sv
design/melody_sequencer.sv
design/tone_generator.sv
design/sfx_arbiter.sv
design/game_audio.sv
tb/game_audio_asserts.sv
tb/game_audio_checker.sv
tb/game_audio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the game_audio testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f game_audio.f \
	--top-module game_audio_tb -o sim_game_audio
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_game_audio)
run_status=$?
printf '%s\n' "$output"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// ==== tb/game_audio_asserts.sv ====
`timescale 1ns/1ns

module game_audio_asserts (
	input logic                       clk,
	input logic                       resetN,
	input logic                       start,
	input logic                       stop,
	input logic                       done,
	input logic                       playing,
	input logic                       check_arb,
	input game_audio_pkg::arb_state_t state
);

	import game_audio_pkg::*;

	int fail_count = 0;

	start_stop_apart: assert property (@(posedge clk) disable iff (!resetN)
		!(start && stop))
		else begin
			$error("start and stop are high in the same cycle");
			fail_count++;
		end

	// The cycle of done is the last one with playing high.
	done_ends_playing: assert property (@(posedge clk) disable iff (!resetN)
		done |=> !playing)
		else begin
			$error("playing stayed high after done");
			fail_count++;
		end

	// A start follows a decision taken in idle or at the end of the menu tune.
	start_from_idle: assert property (@(posedge clk) disable iff (!resetN)
		(check_arb && start) |-> ($past(state, 2) == st_idle || $past(state, 2) == st_menu))
		else begin
			$error("arbiter issued start without an idle decision");
			fail_count++;
		end

endmodule

bind sfx_arbiter game_audio_asserts u_arb_asserts (
	.clk       (clk),
	.resetN    (resetN),
	.start     (start),
	.stop      (stop),
	.done      (1'b0),
	.playing   (1'b0),
	.check_arb (1'b1),
	.state     (state)
);

bind melody_sequencer game_audio_asserts u_seq_asserts (
	.clk       (clk),
	.resetN    (resetN),
	.start     (start),
	.stop      (stop),
	.done      (done),
	.playing   (status.playing),
	.check_arb (1'b0),
	.state     (game_audio_pkg::st_idle)
);

// ==== tb/game_audio_checker.sv ====
`timescale 1ns/1ns

`include "game_audio_macros.svh"

module game_audio_checker (
	input  logic                          clk,
	input  logic                          resetN,
	input  game_audio_pkg::game_events_t  events,
	input  game_audio_pkg::audio_status_t status,
	input  logic                          tone,
	output int                            error_count
);

	import game_audio_pkg::*;

	// ******************************
	// Melody table of the model
	// ******************************

	function automatic note_t table_note(melody_t m, int idx);
		note_t n;
		n = '{p_rest, 3'd1};
		case ({m, 2'(idx)})
			{mel_jewel, 2'd0}: n = '{p_c, 3'd1};
			{mel_jewel, 2'd1}: n = '{p_e, 3'd1};
			{mel_jewel, 2'd2}: n = '{p_g, 3'd1};
			{mel_jewel, 2'd3}: n = '{p_a, 3'd2};
			{mel_power, 2'd0}: n = '{p_e, 3'd2};
			{mel_power, 2'd1}: n = '{p_g, 3'd2};
			{mel_objective, 2'd0}: n = '{p_c, 3'd1};
			{mel_objective, 2'd1}: n = '{p_d, 3'd1};
			{mel_objective, 2'd2}: n = '{p_e, 3'd1};
			{mel_objective, 2'd3}: n = '{p_f, 3'd3};
			{mel_hit, 2'd0}: n = '{p_a, 3'd1};
			{mel_hit, 2'd1}: n = '{p_rest, 3'd1};
			{mel_hit, 2'd2}: n = '{p_a, 3'd1};
			{mel_lost, 2'd0}: n = '{p_g, 3'd2};
			{mel_lost, 2'd1}: n = '{p_f, 3'd2};
			{mel_lost, 2'd2}: n = '{p_e, 3'd2};
			{mel_lost, 2'd3}: n = '{p_c, 3'd4};
			{mel_menu, 2'd0}: n = '{p_c, 3'd3};
			{mel_menu, 2'd1}: n = '{p_e, 3'd3};
			{mel_menu, 2'd2}: n = '{p_g, 3'd3};
			{mel_menu, 2'd3}: n = '{p_e, 3'd3};
			{mel_menu_exit, 2'd0}: n = '{p_g, 3'd1};
			default: n = '{p_rest, 3'd1};
		endcase
		return n;
	endfunction

	function automatic int note_total(melody_t m);
		case (m)
			mel_jewel, mel_objective, mel_lost, mel_menu: return 4;
			mel_hit: return 3;
			mel_power: return 2;
			default: return 1;
		endcase
	endfunction

	function automatic int half_cycles(pitch_t p);
		case (p)
			p_c: return int'(`HALF_PERIOD_C);
			p_d: return int'(`HALF_PERIOD_D);
			p_e: return int'(`HALF_PERIOD_E);
			p_f: return int'(`HALF_PERIOD_F);
			p_g: return int'(`HALF_PERIOD_G);
			default: return int'(`HALF_PERIOD_A);
		endcase
	endfunction

	function automatic int note_cycles(melody_t m, int idx);
		return int'(table_note(m, idx).units) * `NOTE_UNIT_CYCLES;
	endfunction

	task automatic check_value(string name, int expected, int actual);
		if (expected != actual) begin
			$display("** Error at %0t ns: %s expected %0d, got %0d",
				$time, name, expected, actual);
			error_count = error_count + 1;
		end
	endtask

	// Arbiter model.
	arb_state_t a_state;
	melody_t    a_mel;
	melody_t    a_pend;
	logic       a_launch;
	logic       a_start;
	logic       a_stop;
	logic       a_armed;
	logic       a_menu_seen;
	// Sequencer and tone model.
	logic       s_play;
	melody_t    s_mel;
	int         s_idx;
	int         s_rem;
	pitch_t     t_prev;
	int         t_age;
	logic       t_tone;

	initial error_count = 0;

	// ******************************
	// Cycle model
	// ******************************

	always @(posedge clk or negedge resetN) begin : model
		logic    done;
		logic    was_launch;
		pitch_t  cur_pitch;
		melody_t pick;
		if (!resetN) begin
			a_state     = st_idle;
			a_mel       = mel_none;
			a_pend      = mel_none;
			a_launch    = 1'b0;
			a_start     = 1'b0;
			a_stop      = 1'b0;
			a_armed     = 1'b1;
			a_menu_seen = 1'b0;
			s_play      = 1'b0;
			s_mel       = mel_none;
			s_idx       = 0;
			s_rem       = 0;
			t_prev      = p_rest;
			t_age       = 0;
			t_tone      = 1'b0;
		end else begin
			done = s_play && s_rem == 1 && s_idx == note_total(s_mel) - 1;
			cur_pitch = s_play ? table_note(s_mel, s_idx).pitch : p_rest;

			// Tone flips every half-period counted from the pitch change.
			if (cur_pitch != t_prev)
				t_age = 1;
			else
				t_age = t_age + 1;
			t_prev = cur_pitch;
			if (cur_pitch == p_rest)
				t_tone = 1'b0;
			else
				t_tone = ((t_age / half_cycles(cur_pitch)) % 2) == 1;

			if (a_start) begin
				s_play = 1'b1;
				s_mel  = a_mel;
				s_idx  = 0;
				s_rem  = note_cycles(a_mel, 0);
			end else if (a_stop) begin
				s_play = 1'b0;
				s_idx  = 0;
			end else if (s_play) begin
				if (s_rem == 1) begin
					if (done) begin
						s_play = 1'b0;
					end else begin
						s_idx = s_idx + 1;
						s_rem = note_cycles(s_mel, s_idx);
					end
				end else begin
					s_rem = s_rem - 1;
				end
			end

			// Fixed priority for a decision in idle.
			pick = mel_none;
			if (events.jewel)
				pick = mel_jewel;
			else if (events.speed_up || events.extra_life || events.bomb || events.time_bonus)
				pick = mel_power;
			else if (events.objective && events.game_on)
				pick = mel_objective;
			else if (events.player_hit)
				pick = mel_hit;
			else if (events.game_lost && a_armed)
				pick = mel_lost;
			else if (events.main_menu && !a_menu_seen)
				pick = mel_menu;

			was_launch = a_launch;
			a_start  = was_launch;
			a_stop   = 1'b0;
			a_launch = 1'b0;
			if (was_launch)
				a_mel = a_pend;
			if (!events.main_menu)
				a_menu_seen = 1'b0;
			case (a_state)
				st_idle: begin
					if (pick != mel_none) begin
						a_launch = 1'b1;
						a_pend   = pick;
						a_state  = (pick == mel_menu) ? st_menu : st_play;
						if (pick == mel_menu)
							a_menu_seen = 1'b1;
						if (pick == mel_lost)
							a_armed = 1'b0;
					end
				end
				st_play: begin
					if (done && !was_launch)
						a_state = a_armed ? st_idle : st_wait_reset;
				end
				st_wait_reset: begin
					if (events.score_reset) begin
						a_armed = 1'b1;
						a_state = st_idle;
					end
				end
				default: begin
					// Menu closed early or tune finished, the exit chime follows.
					if (!was_launch && (done || !events.main_menu)) begin
						a_stop   = !done;
						a_launch = 1'b1;
						a_pend   = mel_menu_exit;
						a_state  = st_play;
					end
				end
			endcase
		end
	end

	// ******************************
	// Comparison
	// ******************************

	always @(negedge clk) begin
		if (resetN) begin
			check_value("status.playing", int'(s_play), int'(status.playing));
			check_value("status.melody", int'(s_mel), int'(status.melody));
			check_value("status.note_index", s_idx, int'(status.note_index));
			check_value("tone", int'(t_tone), int'(tone));
		end
	end

endmodule

// ==== tb/game_audio_tb.sv ====
`timescale 1ns/1ns

module game_audio_tb;

	import game_audio_pkg::*;

	localparam int RUN_CYCLES   = 3000;
	localparam int RESET_CYCLES = 8;
	// Run length plus the longest melody and margin.
	localparam int TIMEOUT_CYCLES = 3200;

	logic          clk;
	logic          resetN;
	game_events_t  events;
	audio_status_t status;
	logic          tone;
	int            checker_errors;
	int            cycle_count;

	game_audio u_dut (
		.clk    (clk),
		.resetN (resetN),
		.events (events),
		.status (status),
		.tone   (tone)
	);

	game_audio_checker u_chk (
		.clk         (clk),
		.resetN      (resetN),
		.events      (events),
		.status      (status),
		.tone        (tone),
		.error_count (checker_errors)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Sets one of the nine event pulses, chosen by sel.
	function automatic game_events_t raise_pulse(input game_events_t ev, input int sel);
		game_events_t r;
		r = ev;
		case (sel)
			0: r.jewel       = 1'b1;
			1: r.speed_up    = 1'b1;
			2: r.extra_life  = 1'b1;
			3: r.bomb        = 1'b1;
			4: r.time_bonus  = 1'b1;
			5: r.objective   = 1'b1;
			6: r.player_hit  = 1'b1;
			7: r.game_lost   = 1'b1;
			default: r.score_reset = 1'b1;
		endcase
		return r;
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ******************************
	// Timeout
	// ******************************

	initial cycle_count = 0;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ******************************
	// Stimulus
	// ******************************

	initial begin : stimulus
		logic [31:0]  rng;
		game_events_t next_ev;
		int           quiet;
		int           assert_errors;
		resetN = 1'b0;
		events = '0;
		rng    = 32'd40978;
		repeat (RESET_CYCLES) @(posedge clk);
		resetN <= 1'b1;

		for (int i = 0; i < RUN_CYCLES; i++) begin
			@(posedge clk);
			rng = xorshift32(rng);
			next_ev = '0;
			next_ev.main_menu = events.main_menu;
			next_ev.game_on   = events.game_on;
			// Roughly one pulse in forty cycles.
			if (rng[7:0] < 8'd6)
				next_ev = raise_pulse(next_ev, int'(rng[11:8]) % 9);
			// Now and then a second pulse lands in the same cycle.
			if (rng[7:0] < 8'd3)
				next_ev = raise_pulse(next_ev, int'(rng[31:28]) % 9);
			if (rng[19:12] == 8'd0)
				next_ev.main_menu = !events.main_menu;
			if (rng[27:20] < 8'd2)
				next_ev.game_on = !events.game_on;
			events <= next_ev;
		end

		// Let the last tune run out.
		@(posedge clk);
		events <= '0;
		quiet = 0;
		while (quiet < 16) begin
			@(posedge clk);
			if (status.playing)
				quiet = 0;
			else
				quiet = quiet + 1;
		end

		assert_errors = u_dut.u_arbiter.u_arb_asserts.fail_count +
			u_dut.u_sequencer.u_seq_asserts.fail_count;
		$display("Checker errors: %0d, assertion failures: %0d", checker_errors, assert_errors);
		if (checker_errors == 0 && assert_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
